//--- verilog.f
rv32v_mem_pkg.sv
rv32v_mem_serializer.sv
rv32v_load_store_controller.sv
rv32v_write_xbar.sv
stage4_mem_stage.sv
tb_data_mem.sv
tb_stage4_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build the memory stage testbench with Verilator and run it
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_stage4_mem_stage -f verilog.f \
    && ./obj_dir/Vtb_stage4_mem_stage \
    || { echo "Simulation failed"; exit 1; }

//--- tb_stage4_mem_stage.sv
// ----------------------------------------------------------------------
// Testbench for the RV32V memory stage
// Directed scalar and vector tests checked against a byte model of
// the data memory and a model of the four register banks
// ----------------------------------------------------------------------

module tb_stage4_mem_stage;

    // About 400 cycles of tests with worst-case waits, plus margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                                       CLK = 1'b0;
    logic                                       rst_n;
    logic                                       dren, dwen, vmemdren, vmemdwen, vindexed;
    logic                                       bus_busy, bus_ren, bus_wen;
    logic                                       mem_busy, serializer_stall, mal_fault;
    rv32v_mem_pkg::word_t                       addr, store_data, base, stride;
    rv32v_mem_pkg::word_t                       bus_rdata, bus_addr, bus_wdata, load_data;
    rv32v_mem_pkg::word_t [rv32v_mem_pkg::NUM_LANES-1:0]    vlane_addr, vlane_store_data, vwdata;
    rv32v_mem_pkg::byte_en_t [rv32v_mem_pkg::NUM_LANES-1:0] vbyte_wen;
    rv32v_mem_pkg::byte_en_t                    bus_byte_en;
    rv32v_mem_pkg::lane_mask_t                  vlane_mask;
    rv32v_mem_pkg::eew_t                        veew;
    logic [1:0]                                 vuop_num;
    logic [7:0]                                 mem_model [0:1023];
    rv32v_mem_pkg::word_t                       bank_q [4];
    rv32v_mem_pkg::word_t                       rnd_base;
    integer                                     seed = 21892;

    stage4_mem_stage dut_i (.*);
    tb_data_mem mem_i (.*);

    always #10 CLK = ~CLK;

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired after %0d cycles", TIMEOUT_CYCLES);
    end

    task automatic check_value(input string name, input rv32v_mem_pkg::word_t got,
                               input rv32v_mem_pkg::word_t exp);
        assert (got === exp) else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic rv32v_mem_pkg::word_t model_word(input rv32v_mem_pkg::word_t a);
        return {mem_model[a+3], mem_model[a+2], mem_model[a+1], mem_model[a]};
    endfunction

    // One scalar word access, held until mem_busy drops
    task automatic scalar_access(input logic wr, input rv32v_mem_pkg::word_t a,
                                 input rv32v_mem_pkg::word_t d);
        logic mis;
        mis = (a[1:0] != 2'b00);
        @(posedge CLK);
        #2;
        dren       = !wr;
        dwen       = wr;
        addr       = a;
        store_data = d;
        do begin
            @(negedge CLK);
            check_flag("mal_fault", mal_fault, mis);
            check_flag("bus_ren", bus_ren, !wr && !mis);
            check_flag("bus_wen", bus_wen, wr && !mis);
            check_flag("mem_busy", mem_busy, !mis && bus_busy);
            check_flag("serializer_stall", serializer_stall, 1'b0);
            if (!mis) begin
                check_value("bus_addr", bus_addr, {a[31:2], 2'b00});
                check_value("bus_byte_en", 32'(bus_byte_en), 32'hf);
            end
            if (wr && !mis) check_value("bus_wdata", bus_wdata, d);
        end while (mem_busy);
        if (!wr && !mis) check_value("load_data", load_data, model_word(a));
        for (int k = 0; k < 4; k++) begin
            if (wr && !mis) mem_model[a + 32'(k)] = d[8*k +: 8];
        end
        @(posedge CLK);
        #2;
        dren = 1'b0;
        dwen = 1'b0;
    endtask

    // One vector load or store, checked lane by lane
    task automatic vector_op(input logic wr, input logic idx, input rv32v_mem_pkg::word_t b,
                             input rv32v_mem_pkg::word_t str,
                             input rv32v_mem_pkg::lane_mask_t m,
                             input rv32v_mem_pkg::eew_t ew, input logic [1:0] uop);
        rv32v_mem_pkg::word_t          bank_exp [4];
        rv32v_mem_pkg::word_t          ea [4];
        logic                          mis [4];
        rv32v_mem_pkg::byte_en_t [3:0] wen_exp;
        rv32v_mem_pkg::byte_en_t       be_exp;
        int                            nbytes;
        int                            epb;
        int                            e;
        int                            pos;
        int                            lane;
        logic                          active;
        logic                          done;
        nbytes   = (ew == 2'd0) ? 1 : (ew == 2'd1) ? 2 : 4;
        epb      = 4 / nbytes;
        bank_exp = bank_q;
        for (int l = 0; l < 4; l++) begin
            ea[l]  = idx ? b + vlane_addr[l] : b + str * 32'(l);
            mis[l] = (ea[l] % 32'(nbytes)) != 0;
            e      = 4 * int'(uop) + l;
            // Element e lands in bank (e / epb) mod 4 at slot e mod epb
            for (int k = 0; k < nbytes; k++) begin
                if (m[l] && !mis[l] && wr) begin
                    mem_model[ea[l] + 32'(k)] = vlane_store_data[l][8*k +: 8];
                end else if (m[l] && !mis[l]) begin
                    bank_exp[(e / epb) % 4][8 * ((e % epb) * nbytes + k) +: 8] =
                        mem_model[ea[l] + 32'(k)];
                end
            end
        end
        @(posedge CLK);
        #2;
        vmemdren   = !wr;
        vmemdwen   = wr;
        vindexed   = idx;
        base       = b;
        stride     = str;
        vlane_mask = m;
        veew       = ew;
        vuop_num   = uop;
        lane       = 0;
        while (lane < 4) begin
            @(negedge CLK);
            active = m[lane] && !mis[lane];
            check_flag("mal_fault", mal_fault, m[lane] && mis[lane]);
            check_flag("bus_ren", bus_ren, active && !wr);
            check_flag("bus_wen", bus_wen, active && wr);
            check_flag("mem_busy", mem_busy, 1'b0);
            if (active) begin
                be_exp = rv32v_mem_pkg::byte_en_t'(((1 << nbytes) - 1) << ea[lane][1:0]);
                check_value("bus_addr", bus_addr, {ea[lane][31:2], 2'b00});
                check_value("bus_byte_en", 32'(bus_byte_en), 32'(be_exp));
            end
            // Store element bytes sit at the lanes picked by the low address bits
            if (active && wr) begin
                for (int k = 0; k < nbytes; k++) begin
                    pos = 8 * (int'(ea[lane][1:0]) + k);
                    check_value("bus_wdata", 32'(bus_wdata[pos +: 8]),
                                32'(vlane_store_data[lane][8*k +: 8]));
                end
            end
            done    = !active || !bus_busy;
            wen_exp = '0;
            if (done && active && !wr) begin
                e = 4 * int'(uop) + lane;
                wen_exp[(e / epb) % 4] =
                    rv32v_mem_pkg::byte_en_t'(((1 << nbytes) - 1) << ((e % epb) * nbytes));
            end
            check_value("vbyte_wen", 32'(vbyte_wen), 32'(wen_exp));
            for (int i = 0; i < 4; i++) begin
                for (int k = 0; k < 4; k++) begin
                    if (vbyte_wen[i][k]) bank_q[i][8*k +: 8] = vwdata[i][8*k +: 8];
                end
            end
            if (done) lane++;
            check_flag("serializer_stall", serializer_stall, lane < 4);
        end
        @(posedge CLK);
        #2;
        vmemdren = 1'b0;
        vmemdwen = 1'b0;
        for (int i = 0; i < 4; i++) check_value($sformatf("bank%0d", i), bank_q[i], bank_exp[i]);
    endtask

    task automatic indexed_byte_store(input rv32v_mem_pkg::word_t b);
        vector_op(1'b1, 1'b1, b, 32'd0, 4'b1111, 2'd0, 2'd0);
        // Read back the four words around the stored bytes
        for (int w = 0; w < 4; w++) begin
            scalar_access(1'b0, {b[31:2], 2'b00} + 32'(4 * w), 32'd0);
        end
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            for (int k = 0; k < 4; k++) begin
                mem_model[4*i+k] = 8'(rv32v_mem_pkg::word_t'(
                    {8'(i) ^ 8'h5a, ~8'(i), 8'(i) + 8'h31, 8'(i)}) >> (8 * k));
            end
        end
        for (int i = 0; i < 4; i++) bank_q[i] = '0;
        rst_n            = 1'b0;
        dren             = 1'b0;
        dwen             = 1'b0;
        vmemdren         = 1'b0;
        vmemdwen         = 1'b0;
        vindexed         = 1'b0;
        addr             = '0;
        store_data       = '0;
        base             = '0;
        stride           = '0;
        vlane_addr       = '0;
        vlane_store_data = '0;
        vlane_mask       = '0;
        veew             = '0;
        vuop_num         = '0;
        repeat (10) @(posedge CLK);
        #2;
        rst_n = 1'b1;

        // Scalar round trip
        scalar_access(1'b1, 32'h010, 32'hdeadbeef);
        scalar_access(1'b1, 32'h3fc, 32'h0badf00d);
        scalar_access(1'b1, 32'h124, 32'h13572468);
        scalar_access(1'b0, 32'h010, 32'd0);
        scalar_access(1'b0, 32'h3fc, 32'd0);
        scalar_access(1'b0, 32'h124, 32'd0);

        // Unit-stride word load, then strided halfword load
        vector_op(1'b0, 1'b0, 32'h040, 32'd4, 4'b1111, 2'd2, 2'd0);
        vector_op(1'b0, 1'b0, 32'h082, 32'd6, 4'b1011, 2'd1, 2'd1);

        vlane_addr       = {32'd12, 32'd11, 32'd6, 32'd1};
        vlane_store_data = {32'h111111a4, 32'h222222b3, 32'h333333c2, 32'h444444d1};
        indexed_byte_store(32'h200);

        // Misaligned halfword in lane 2, then a misaligned scalar load and store
        vlane_addr = {32'd6, 32'd5, 32'd2, 32'd0};
        vector_op(1'b0, 1'b1, 32'h100, 32'd0, 4'b1111, 2'd1, 2'd2);
        scalar_access(1'b0, 32'h102, 32'd0);
        scalar_access(1'b1, 32'h102, 32'hffffffff);
        scalar_access(1'b0, 32'h100, 32'd0);

        for (int n = 0; n < 4; n++) begin
            rnd_base = ($unsigned($random(seed)) % 240) << 2;
            vector_op(1'b0, 1'b0, rnd_base, 32'd4, 4'b1111, 2'd2, 2'd0);
            rnd_base = ($unsigned($random(seed)) % 400) << 1;
            vector_op(1'b0, 1'b0, rnd_base, ($unsigned($random(seed)) % 8) << 1,
                      4'($random(seed)), 2'd1, 2'($random(seed)));
            for (int l = 0; l < 4; l++) begin
                vlane_addr[l]       = $unsigned($random(seed)) % 16;
                vlane_store_data[l] = $random(seed);
            end
            indexed_byte_store(($unsigned($random(seed)) % 240) << 2);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- tb_data_mem.sv
// ----------------------------------------------------------------------
// Testbench data memory
// 256-word bus responder that holds busy for 0 to 2 random cycles on
// each access and completes it in the first non-busy cycle
// ----------------------------------------------------------------------

module tb_data_mem (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       bus_ren,
    input  logic                       bus_wen,
    input  rv32v_mem_pkg::word_t       bus_addr,
    input  rv32v_mem_pkg::word_t       bus_wdata,
    input  rv32v_mem_pkg::byte_en_t    bus_byte_en,
    output rv32v_mem_pkg::word_t       bus_rdata,
    output logic                       bus_busy
);

    rv32v_mem_pkg::word_t mem [0:255];
    logic [1:0]           wait_cnt;
    logic [1:0]           wait_len;
    integer               seed = 21892;

    // Same fill pattern as the testbench byte model
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i) + 8'h31, 8'(i)};
        end
    end

    assign bus_rdata = mem[bus_addr[9:2]];
    assign bus_busy  = (bus_ren | bus_wen) & (wait_cnt != wait_len);

    always @(posedge CLK) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            wait_len <= '0;
        end else if (bus_busy) begin
            wait_cnt <= wait_cnt + 2'd1;
        end else if (bus_ren | bus_wen) begin
            // Completing cycle draws the wait of the next access
            wait_cnt <= '0;
            wait_len <= 2'($unsigned($random(seed)) % 3);
            for (int k = 0; k < 4; k++) begin
                if (bus_wen && bus_byte_en[k]) begin
                    mem[bus_addr[9:2]][8*k +: 8] <= bus_wdata[8*k +: 8];
                end
            end
        end
    end

endmodule

//--- stage4_mem_stage.sv
// ----------------------------------------------------------------------
// RV32V memory stage
// Arbitrates scalar word accesses and serialized vector element
// accesses into one load-store controller, and steers vector load
// elements into the register banks through per-bank crossbars.
// ----------------------------------------------------------------------

module stage4_mem_stage (
    input  logic                                                  CLK,
    input  logic                                                  rst_n,
    // Scalar request
    input  logic                                                  dren,
    input  logic                                                  dwen,
    input  rv32v_mem_pkg::word_t                                  addr,
    input  rv32v_mem_pkg::word_t                                  store_data,
    // Vector request
    input  logic                                                  vmemdren,
    input  logic                                                  vmemdwen,
    input  logic                                                  vindexed,
    input  rv32v_mem_pkg::word_t                                  base,
    input  rv32v_mem_pkg::word_t                                  stride,
    input  rv32v_mem_pkg::word_t [rv32v_mem_pkg::NUM_LANES-1:0]   vlane_addr,
    input  rv32v_mem_pkg::word_t [rv32v_mem_pkg::NUM_LANES-1:0]   vlane_store_data,
    input  rv32v_mem_pkg::lane_mask_t                             vlane_mask,
    input  rv32v_mem_pkg::eew_t                                   veew,
    input  logic [1:0]                                            vuop_num,
    // Data bus
    input  rv32v_mem_pkg::word_t                                  bus_rdata,
    input  logic                                                  bus_busy,
    output logic                                                  bus_ren,
    output logic                                                  bus_wen,
    output rv32v_mem_pkg::word_t                                  bus_addr,
    output rv32v_mem_pkg::word_t                                  bus_wdata,
    output rv32v_mem_pkg::byte_en_t                               bus_byte_en,
    // Pipeline side
    output rv32v_mem_pkg::word_t                                  load_data,
    output logic                                                  mem_busy,
    output logic                                                  serializer_stall,
    output logic                                                  mal_fault,
    output rv32v_mem_pkg::word_t [rv32v_mem_pkg::NUM_LANES-1:0]   vwdata,
    output rv32v_mem_pkg::byte_en_t [rv32v_mem_pkg::NUM_LANES-1:0] vbyte_wen
);

    logic                            vmemop;
    logic                            ser_ren;
    logic                            ser_wen;
    rv32v_mem_pkg::word_t            ser_addr;
    rv32v_mem_pkg::word_t            ser_wdata;
    rv32v_mem_pkg::lane_idx_t        curr_lane;
    logic                            lsc_ready;
    logic                            lsc_ren;
    logic                            lsc_wen;
    rv32v_mem_pkg::word_t            lsc_addr;
    rv32v_mem_pkg::word_t            lsc_wdata;
    rv32v_mem_pkg::eew_t             lsc_eew;
    logic                            mal_addr;
    rv32v_mem_pkg::word_t            dload_ext;
    rv32v_mem_pkg::lane_mask_t       vlane_wen;

    assign vmemop = vmemdren | vmemdwen;

    rv32v_mem_serializer slzr_i (
        .CLK              (CLK),
        .rst_n            (rst_n),
        .vmemdren         (vmemdren),
        .vmemdwen         (vmemdwen),
        .vindexed         (vindexed),
        .base             (base),
        .stride           (stride),
        .vlane_addr       (vlane_addr),
        .vlane_store_data (vlane_store_data),
        .vlane_mask       (vlane_mask),
        .lsc_ready        (lsc_ready),
        .lsc_ren          (ser_ren),
        .lsc_wen          (ser_wen),
        .lsc_addr         (ser_addr),
        .lsc_wdata        (ser_wdata),
        .curr_lane        (curr_lane),
        .serializer_stall (serializer_stall)
    );

    // Scalar accesses are always word wide
    assign lsc_ren   = vmemop ? ser_ren   : dren;
    assign lsc_wen   = vmemop ? ser_wen   : dwen;
    assign lsc_addr  = vmemop ? ser_addr  : addr;
    assign lsc_wdata = vmemop ? ser_wdata : store_data;
    assign lsc_eew   = vmemop ? veew      : rv32v_mem_pkg::EEW_WORD;

    rv32v_load_store_controller lsc_i (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .ren         (lsc_ren),
        .wen         (lsc_wen),
        .addr        (lsc_addr),
        .store_data  (lsc_wdata),
        .eew         (lsc_eew),
        .bus_rdata   (bus_rdata),
        .bus_busy    (bus_busy),
        .bus_ren     (bus_ren),
        .bus_wen     (bus_wen),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_byte_en (bus_byte_en),
        .lsc_ready   (lsc_ready),
        .mal_addr    (mal_addr),
        .dload_ext   (dload_ext)
    );

    assign load_data = dload_ext;
    assign mal_fault = mal_addr;

    // Scalar access still waiting on the bus
    assign mem_busy = ~vmemop & (bus_ren | bus_wen) & bus_busy;

    // Only the lane completing a clean vector load writes back
    always_comb begin
        vlane_wen            = '0;
        vlane_wen[curr_lane] = vmemdren & lsc_ready & ~mal_addr;
    end

    for (genvar i = 0; i < rv32v_mem_pkg::NUM_LANES; i++) begin : gen_wb_xbar
        rv32v_write_xbar #(
            .BANK_NUM (i)
        ) wbxbar_i (
            .lane_dat    ({rv32v_mem_pkg::NUM_LANES{dload_ext}}),
            .lane_wen    (vlane_wen),
            .eew         (veew),
            .bank_offset (vuop_num),
            .vwdat       (vwdata[i]),
            .byte_wen    (vbyte_wen[i])
        );
    end

endmodule

//--- rv32v_write_xbar.sv
// ----------------------------------------------------------------------
// Vector write-back crossbar for one register bank
// Picks the lane elements that map to this bank for the current
// micro-op and places their bytes at the element's slot.
// ----------------------------------------------------------------------

module rv32v_write_xbar #(
    parameter int BANK_NUM = 0
) (
    input  rv32v_mem_pkg::word_t [rv32v_mem_pkg::NUM_LANES-1:0]   lane_dat,
    input  rv32v_mem_pkg::lane_mask_t                             lane_wen,
    input  rv32v_mem_pkg::eew_t                                   eew,
    input  rv32v_mem_pkg::lane_idx_t                              bank_offset,
    output rv32v_mem_pkg::word_t                                  vwdat,
    output rv32v_mem_pkg::byte_en_t                               byte_wen
);

    localparam logic [1:0] BANK = 2'(BANK_NUM);

    logic [3:0] elem;

    always_comb begin
        vwdat    = '0;
        byte_wen = '0;
        elem     = '0;
        for (int lane = 0; lane < rv32v_mem_pkg::NUM_LANES; lane++) begin
            // Element index within the register group
            elem = {bank_offset, 2'(lane)};
            if (lane_wen[lane]) begin
                case (eew)
                    rv32v_mem_pkg::EEW_BYTE: begin
                        if (elem[3:2] == BANK) begin
                            vwdat[8*elem[1:0] +: 8] = lane_dat[lane][7:0];
                            byte_wen[elem[1:0]]     = 1'b1;
                        end
                    end
                    rv32v_mem_pkg::EEW_HALF: begin
                        if (elem[2:1] == BANK) begin
                            vwdat[16*elem[0] +: 16]  = lane_dat[lane][15:0];
                            byte_wen[2*elem[0] +: 2] = 2'b11;
                        end
                    end
                    default: begin
                        if (elem[1:0] == BANK) begin
                            vwdat    = lane_dat[lane];
                            byte_wen = 4'b1111;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- rv32v_load_store_controller.sv
// ----------------------------------------------------------------------
// Load-store controller
// Turns one byte, halfword or word access into a data bus request,
// with byte enables and replicated store data, and returns the load
// element zero-extended. Misaligned accesses never reach the bus.
// ----------------------------------------------------------------------

module rv32v_load_store_controller (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       ren,
    input  logic                       wen,
    input  rv32v_mem_pkg::word_t       addr,
    input  rv32v_mem_pkg::word_t       store_data,
    input  rv32v_mem_pkg::eew_t        eew,
    input  rv32v_mem_pkg::word_t       bus_rdata,
    input  logic                       bus_busy,
    output logic                       bus_ren,
    output logic                       bus_wen,
    output rv32v_mem_pkg::word_t       bus_addr,
    output rv32v_mem_pkg::word_t       bus_wdata,
    output rv32v_mem_pkg::byte_en_t    bus_byte_en,
    output logic                       lsc_ready,
    output logic                       mal_addr,
    output rv32v_mem_pkg::word_t       dload_ext
);

    logic                    misaligned;
    logic                    bus_req;
    logic                    pending_q;
    rv32v_mem_pkg::byte_en_t byte_en;
    rv32v_mem_pkg::word_t    rdata_shift;

    // Requested bytes moved down to bit 0
    assign rdata_shift = bus_rdata >> {addr[1:0], 3'b000};

    always_comb begin
        misaligned = 1'b0;
        byte_en    = 4'b1111;
        bus_wdata  = store_data;
        dload_ext  = bus_rdata;
        case (eew)
            rv32v_mem_pkg::EEW_BYTE: begin
                byte_en   = rv32v_mem_pkg::byte_en_t'(4'b0001 << addr[1:0]);
                bus_wdata = {4{store_data[7:0]}};
                dload_ext = {24'h0, rdata_shift[7:0]};
            end
            rv32v_mem_pkg::EEW_HALF: begin
                misaligned = addr[0];
                byte_en    = addr[1] ? 4'b1100 : 4'b0011;
                bus_wdata  = {2{store_data[15:0]}};
                dload_ext  = {16'h0, rdata_shift[15:0]};
            end
            default: begin
                // Word, and the reserved code
                misaligned = |addr[1:0];
            end
        endcase
    end

    assign bus_ren     = ren & ~misaligned;
    assign bus_wen     = wen & ~misaligned;
    assign bus_req     = bus_ren | bus_wen;
    assign bus_addr    = {addr[31:2], 2'b00};
    assign bus_byte_en = bus_req ? byte_en : '0;

    // Set while a bus access waits on busy
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= bus_req & bus_busy;
        end
    end

    // An access already waiting on the bus is never reported as a fault
    assign mal_addr = (ren | wen) & misaligned & ~pending_q;

    // Complete on the first non-busy bus cycle, or at once on a fault
    assign lsc_ready = mal_addr | (bus_req & ~bus_busy);

endmodule

//--- rv32v_mem_serializer.sv
// ----------------------------------------------------------------------
// Vector memory serializer
// Walks the four lanes in order and issues one element access per
// active lane to the load-store controller. Masked lanes take a
// single cycle with no access.
// ----------------------------------------------------------------------

module rv32v_mem_serializer (
    input  logic                                                  CLK,
    input  logic                                                  rst_n,
    input  logic                                                  vmemdren,
    input  logic                                                  vmemdwen,
    input  logic                                                  vindexed,
    input  rv32v_mem_pkg::word_t                                  base,
    input  rv32v_mem_pkg::word_t                                  stride,
    input  rv32v_mem_pkg::word_t [rv32v_mem_pkg::NUM_LANES-1:0]   vlane_addr,
    input  rv32v_mem_pkg::word_t [rv32v_mem_pkg::NUM_LANES-1:0]   vlane_store_data,
    input  rv32v_mem_pkg::lane_mask_t                             vlane_mask,
    input  logic                                                  lsc_ready,
    output logic                                                  lsc_ren,
    output logic                                                  lsc_wen,
    output rv32v_mem_pkg::word_t                                  lsc_addr,
    output rv32v_mem_pkg::word_t                                  lsc_wdata,
    output rv32v_mem_pkg::lane_idx_t                              curr_lane,
    output logic                                                  serializer_stall
);

    localparam rv32v_mem_pkg::lane_idx_t LAST_LANE =
        rv32v_mem_pkg::lane_idx_t'(rv32v_mem_pkg::NUM_LANES - 1);

    rv32v_mem_pkg::ser_state_t state;
    rv32v_mem_pkg::lane_idx_t  lane_q;
    logic                      vmemop;
    logic                      lane_active;
    logic                      lane_done;

    assign vmemop = vmemdren | vmemdwen;

    // A fresh operation always begins at lane 0
    assign curr_lane = (state == rv32v_mem_pkg::SER_IDLE) ? '0 : lane_q;

    assign lane_active = vlane_mask[curr_lane];
    assign lane_done   = ~lane_active | lsc_ready;

    assign lsc_ren = vmemdren & lane_active;
    assign lsc_wen = vmemdwen & lane_active;

    // Indexed uses per-lane offsets, strided uses lane times stride
    assign lsc_addr = vindexed ? (base + vlane_addr[curr_lane])
                               : (base + stride * rv32v_mem_pkg::word_t'(curr_lane));
    assign lsc_wdata = vlane_store_data[curr_lane];

    // Drops in the completing cycle of the last lane
    assign serializer_stall = vmemop & ~(lane_done & (curr_lane == LAST_LANE));

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state  <= rv32v_mem_pkg::SER_IDLE;
            lane_q <= '0;
        end else if (!vmemop) begin
            state  <= rv32v_mem_pkg::SER_IDLE;
        end else if (lane_done) begin
            if (curr_lane == LAST_LANE) begin
                state  <= rv32v_mem_pkg::SER_IDLE;
            end else begin
                state  <= rv32v_mem_pkg::SER_LANE;
                lane_q <= curr_lane + 2'd1;
            end
        end
    end

endmodule

//--- rv32v_mem_pkg.sv
// ----------------------------------------------------------------------
// RV32V memory stage package
// Widths, lane count, element width codes and the serializer states
// shared by the memory stage blocks
// ----------------------------------------------------------------------

package rv32v_mem_pkg;

    // Lanes and register banks
    localparam int NUM_LANES = 4;

    // Data or address word
    typedef logic [31:0] word_t;

    // One bit per lane
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // Lane number
    typedef logic [1:0] lane_idx_t;

    // One bit per byte of a word
    typedef logic [3:0] byte_en_t;

    // Element width code, 3 is reserved and handled as word
    typedef logic [1:0] eew_t;

    localparam eew_t EEW_BYTE = 2'd0;
    localparam eew_t EEW_HALF = 2'd1;
    localparam eew_t EEW_WORD = 2'd2;

    // Serializer FSM
    typedef enum logic {
        SER_IDLE,
        SER_LANE
    } ser_state_t;

endpackage
